// File: Makefile
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module nic_rx_tb -Mdir obj_dir -f list.f
	./obj_dir/Vnic_rx_tb | tee $(LOG)
	grep -q "^\*\* PASS \*\*$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: list.f
+incdir+rtl
rtl/nic_pkg.sv
rtl/rx_frame_writer.sv
rtl/rx_buffer.sv
rtl/rx_tlp_trigger.sv
rtl/nic_rx_top.sv
tests/nic_rx_chk.sv
tests/nic_rx_tb.sv

// File: rtl/nic_defines.svh
`ifndef NIC_DEFINES_SVH
`define NIC_DEFINES_SVH

// --------------------
// Receive buffer geometry
// --------------------
`define NIC_BUF_ADDR_BITS   9      // 512 qwords in the ring
`define NIC_QWORD_BITS      64     // One MAC beat
`define NIC_BYTE_LANES      8      // Byte-valid lanes per beat

// --------------------
// Host request shaping
// --------------------
`define NIC_MAX_TLP_QWORDS  16     // Largest read request
`define NIC_TLP_TIMEOUT     64     // Idle cycles before tail flush

// --------------------
// Instrumentation
// --------------------
`define NIC_STAT_BITS       32     // Frame counter width

`endif

// File: rtl/nic_pkg.sv
`include "nic_defines.svh"

package nic_pkg;

    // --------------------
    // Data and address widths
    // --------------------
    typedef logic [`NIC_BUF_ADDR_BITS-1:0] buf_addr_t;    // Ring index
    typedef logic [`NIC_QWORD_BITS-1:0]    qword_t;       // Payload beat
    typedef logic [`NIC_BYTE_LANES-1:0]    byte_valid_t;  // MAC lane enables

    // Counts 0 to 16 inclusive
    typedef logic [$clog2(`NIC_MAX_TLP_QWORDS+1)-1:0] tlp_qwords_t;

    typedef logic [`NIC_STAT_BITS-1:0]     frame_count_t; // Statistics

    // --------------------
    // State machines
    // --------------------
    typedef enum logic [1:0] {
        WR_IDLE,                   // Between frames
        WR_FRAME,                  // Storing qwords
        WR_DROP                    // Discarding rest of frame
    } wr_state_t;

    typedef enum logic {
        TRIG_IDLE,                 // Watching committed data
        TRIG_WAIT_ACK              // Request held for host
    } trig_state_t;

endpackage

// File: rtl/nic_rx_top.sv
`timescale 1ns/1ps

module nic_rx_top
    import nic_pkg::*;
(
    input  logic         xaui_clk_156_25_out,
    input  logic         reset_n,
    // MAC receive interface
    input  qword_t       rx_data,
    input  byte_valid_t  rx_data_valid,
    input  logic         rx_good_frame,
    input  logic         rx_bad_frame,
    // Host read pointer return
    input  logic         rd_addr_updated,
    input  buf_addr_t    committed_rd_address,
    // Host buffer read port
    input  buf_addr_t    rd_addr,
    output qword_t       rd_data,
    // Host request handshake
    input  logic         trigger_tlp_ack,
    output buf_addr_t    committed_wr_address,
    output logic         trigger_tlp,
    output tlp_qwords_t  qwords_to_send,
    // Instrumentation
    output frame_count_t good_frames,
    output frame_count_t bad_frames,
    output frame_count_t dropped_frames
);

    // --------------------
    // Writer to buffer
    // --------------------
    logic      wr_en;
    buf_addr_t wr_addr;
    qword_t    wr_data;

    // --------------------
    // Frame writer
    // --------------------
    rx_frame_writer rx_frame_writer0 (
        .xaui_clk_156_25_out  (xaui_clk_156_25_out),
        .reset_n              (reset_n),
        .rx_data              (rx_data),
        .rx_data_valid        (rx_data_valid),
        .rx_good_frame        (rx_good_frame),
        .rx_bad_frame         (rx_bad_frame),
        .rd_addr_updated      (rd_addr_updated),       // From host
        .committed_rd_address (committed_rd_address),  // From host
        .wr_en                (wr_en),
        .wr_addr              (wr_addr),
        .wr_data              (wr_data),
        .committed_wr_address (committed_wr_address),  // Also feeds trigger
        .good_frames          (good_frames),
        .bad_frames           (bad_frames),
        .dropped_frames       (dropped_frames)
    );

    // --------------------
    // Qword ring
    // --------------------
    rx_buffer rx_buffer0 (
        .xaui_clk_156_25_out (xaui_clk_156_25_out),
        .wr_en               (wr_en),
        .wr_addr             (wr_addr),
        .wr_data             (wr_data),
        .rd_addr             (rd_addr),                // Host side
        .rd_data             (rd_data)                 // One cycle later
    );

    // --------------------
    // Read request trigger
    // --------------------
    rx_tlp_trigger rx_tlp_trigger0 (
        .xaui_clk_156_25_out  (xaui_clk_156_25_out),
        .reset_n              (reset_n),
        .committed_wr_address (committed_wr_address),
        .trigger_tlp_ack      (trigger_tlp_ack),
        .trigger_tlp          (trigger_tlp),
        .qwords_to_send       (qwords_to_send)
    );

endmodule

// File: rtl/rx_buffer.sv
`timescale 1ns/1ps
`include "nic_defines.svh"

module rx_buffer
    import nic_pkg::*;
(
    input  logic      xaui_clk_156_25_out,
    // Write side, from frame writer
    input  logic      wr_en,
    input  buf_addr_t wr_addr,
    input  qword_t    wr_data,
    // Read side, from host
    input  buf_addr_t rd_addr,
    output qword_t    rd_data           // Valid one cycle after rd_addr
);

    localparam int DEPTH = 1 << `NIC_BUF_ADDR_BITS;   // 512 qwords

    qword_t mem [0:DEPTH-1];            // Ring storage

    // --------------------
    // Write port
    // --------------------
    always_ff @(posedge xaui_clk_156_25_out) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;    // Visible to reads next cycle
        end
    end

    // --------------------
    // Registered read port
    // --------------------
    // Same-address collision returns the old word, but the writer
    // never touches a qword the host can still fetch
    always_ff @(posedge xaui_clk_156_25_out) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: rtl/rx_frame_writer.sv
`timescale 1ns/1ps

module rx_frame_writer
    import nic_pkg::*;
(
    input  logic         xaui_clk_156_25_out,
    input  logic         reset_n,
    // MAC receive beats
    input  qword_t       rx_data,
    input  byte_valid_t  rx_data_valid,
    input  logic         rx_good_frame,         // End of frame, FCS ok
    input  logic         rx_bad_frame,          // End of frame, discard
    // Host read progress
    input  logic         rd_addr_updated,       // Strobe
    input  buf_addr_t    committed_rd_address,  // Next unconsumed qword
    // Buffer write port
    output logic         wr_en,
    output buf_addr_t    wr_addr,
    output qword_t       wr_data,
    // Toward TLP trigger
    output buf_addr_t    committed_wr_address,  // One past last good frame
    // Instrumentation
    output frame_count_t good_frames,
    output frame_count_t bad_frames,
    output frame_count_t dropped_frames
);

    wr_state_t  wr_state;       // Frame FSM
    buf_addr_t  wr_ptr;         // Working write pointer
    buf_addr_t  rd_ptr_q;       // Last host read pointer seen
    buf_addr_t  next_wr_ptr;    // Pointer after this qword
    logic       qword_in;       // Any lane valid
    logic       frame_end;      // Good or bad strobe
    logic       buffer_full;    // Next write would catch the host
    logic       accept_qword;   // Qword goes to RAM

    // --------------------
    // Beat decode and full test
    // --------------------
    assign qword_in    = |rx_data_valid;         // Whole qword stored
    assign frame_end   = rx_good_frame | rx_bad_frame;
    assign next_wr_ptr = wr_ptr + 1'b1;          // Wraps at 512
    assign buffer_full = (next_wr_ptr == rd_ptr_q);

    // Strobes never share a cycle with data, priority kept anyway
    assign accept_qword = qword_in && !frame_end && !buffer_full &&
                          (wr_state != WR_DROP);

    // Write port follows the MAC beat directly
    assign wr_en   = accept_qword;
    assign wr_addr = wr_ptr;
    assign wr_data = rx_data;

    // --------------------
    // Host read pointer
    // --------------------
    always_ff @(posedge xaui_clk_156_25_out or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr_q <= '0;                      // Ring starts empty
        end else if (rd_addr_updated) begin
            rd_ptr_q <= committed_rd_address;    // Sampled on strobe only
        end
    end

    // --------------------
    // Frame FSM
    // --------------------
    always_ff @(posedge xaui_clk_156_25_out or negedge reset_n) begin
        if (!reset_n) begin
            wr_state             <= WR_IDLE;
            wr_ptr               <= '0;
            committed_wr_address <= '0;
        end else begin
            case (wr_state)
                WR_IDLE, WR_FRAME: begin
                    if (rx_good_frame) begin
                        committed_wr_address <= wr_ptr;   // Publish frame
                        wr_state             <= WR_IDLE;
                    end else if (rx_bad_frame) begin
                        wr_ptr   <= committed_wr_address; // Rewind
                        wr_state <= WR_IDLE;
                    end else if (qword_in) begin
                        if (buffer_full) begin
                            wr_state <= WR_DROP;          // No room, give up frame
                        end else begin
                            wr_ptr   <= next_wr_ptr;
                            wr_state <= WR_FRAME;
                        end
                    end
                end

                WR_DROP: begin
                    // Either strobe closes a dropped frame
                    if (frame_end) begin
                        wr_ptr   <= committed_wr_address;
                        wr_state <= WR_IDLE;
                    end
                end

                default: begin
                    wr_state <= WR_IDLE;
                end
            endcase
        end
    end

    // --------------------
    // Frame counters
    // --------------------
    always_ff @(posedge xaui_clk_156_25_out or negedge reset_n) begin
        if (!reset_n) begin
            good_frames    <= '0;
            bad_frames     <= '0;
            dropped_frames <= '0;
        end else begin
            if (wr_state == WR_DROP && frame_end) begin
                dropped_frames <= dropped_frames + 1'b1;  // Counted once only
            end else if (rx_good_frame) begin
                good_frames <= good_frames + 1'b1;        // Same edge as commit
            end else if (rx_bad_frame) begin
                bad_frames <= bad_frames + 1'b1;          // Same edge as rewind
            end
        end
    end

endmodule

// File: rtl/rx_tlp_trigger.sv
`timescale 1ns/1ps
`include "nic_defines.svh"

module rx_tlp_trigger
    import nic_pkg::*;
(
    input  logic        xaui_clk_156_25_out,
    input  logic        reset_n,
    // From frame writer
    input  buf_addr_t   committed_wr_address,  // Level, one past newest frame
    // Host handshake
    input  logic        trigger_tlp_ack,       // One-cycle strobe
    output logic        trigger_tlp,           // Held until ack
    output tlp_qwords_t qwords_to_send         // Stable while trigger high
);

    localparam int TIMER_BITS = $clog2(`NIC_TLP_TIMEOUT + 1);

    trig_state_t           trig_state;
    buf_addr_t             sent_ptr;          // First qword not yet requested
    buf_addr_t             wr_addr_q;         // Previous committed address
    buf_addr_t             pending;           // Committed but not requested
    logic [TIMER_BITS-1:0] idle_cnt;          // Cycles with no new commit
    logic                  addr_changed;      // Writer committed a frame
    logic                  full_ready;        // A whole request is waiting
    logic                  tail_ready;        // Partial tail has timed out

    // --------------------
    // Pending data
    // --------------------
    assign pending      = committed_wr_address - sent_ptr;   // Modulo 512
    assign addr_changed = (committed_wr_address != wr_addr_q);
    assign full_ready   = (pending >= buf_addr_t'(`NIC_MAX_TLP_QWORDS));
    assign tail_ready   = (pending != '0) &&
                          (idle_cnt == TIMER_BITS'(`NIC_TLP_TIMEOUT));

    // Track commits for the idle timer
    always_ff @(posedge xaui_clk_156_25_out or negedge reset_n) begin
        if (!reset_n) begin
            wr_addr_q <= '0;
        end else begin
            wr_addr_q <= committed_wr_address;
        end
    end

    // --------------------
    // Request FSM
    // --------------------
    always_ff @(posedge xaui_clk_156_25_out or negedge reset_n) begin
        if (!reset_n) begin
            trig_state     <= TRIG_IDLE;
            sent_ptr       <= '0;           // Requests start at address 0
            idle_cnt       <= '0;
            trigger_tlp    <= 1'b0;
            qwords_to_send <= '0;
        end else begin
            case (trig_state)
                TRIG_IDLE: begin
                    if (full_ready) begin
                        trigger_tlp    <= 1'b1;     // Full request right away
                        qwords_to_send <= tlp_qwords_t'(`NIC_MAX_TLP_QWORDS);
                        idle_cnt       <= '0;
                        trig_state     <= TRIG_WAIT_ACK;
                    end else if (tail_ready) begin
                        trigger_tlp    <= 1'b1;     // Flush short tail
                        qwords_to_send <= tlp_qwords_t'(pending);
                        idle_cnt       <= '0;
                        trig_state     <= TRIG_WAIT_ACK;
                    end else if (addr_changed || pending == '0) begin
                        idle_cnt <= '0;             // Restart quiet period
                    end else if (idle_cnt != TIMER_BITS'(`NIC_TLP_TIMEOUT)) begin
                        idle_cnt <= idle_cnt + 1'b1;
                    end
                end

                TRIG_WAIT_ACK: begin
                    // Host may stall here without limit
                    if (trigger_tlp_ack) begin
                        trigger_tlp <= 1'b0;
                        sent_ptr    <= sent_ptr + buf_addr_t'(qwords_to_send);
                        idle_cnt    <= '0;
                        trig_state  <= TRIG_IDLE;   // Low for at least a cycle
                    end
                end

                default: begin
                    trig_state  <= TRIG_IDLE;
                    trigger_tlp <= 1'b0;
                end
            endcase
        end
    end

endmodule

// File: tests/nic_rx_chk.sv
`timescale 1ns/1ps
`include "nic_defines.svh"

module nic_rx_chk
    import nic_pkg::*;
(
    input logic         xaui_clk_156_25_out,
    input logic         reset_n,
    input logic         trigger_tlp,
    input logic         trigger_tlp_ack,
    input tlp_qwords_t  qwords_to_send,
    input logic         rd_addr_updated,
    input buf_addr_t    committed_rd_address,
    input buf_addr_t    committed_wr_address,
    input frame_count_t good_frames,
    input frame_count_t bad_frames,
    input frame_count_t dropped_frames
);

    buf_addr_t host_rd_q;   // Host pointer as the writer holds it

    always_ff @(posedge xaui_clk_156_25_out or negedge reset_n) begin
        if (!reset_n) begin
            host_rd_q <= '0;
        end else if (rd_addr_updated) begin
            host_rd_q <= committed_rd_address;   // Strobe cycle only
        end
    end

    // --------------------
    // Request handshake
    // --------------------
    req_held: assert property (@(posedge xaui_clk_156_25_out) disable iff (!reset_n)
        trigger_tlp && !trigger_tlp_ack |=> trigger_tlp && $stable(qwords_to_send))
        else $error("Request changed or dropped before its acknowledge");

    req_release: assert property (@(posedge xaui_clk_156_25_out) disable iff (!reset_n)
        trigger_tlp && trigger_tlp_ack |=> !trigger_tlp)
        else $error("trigger_tlp still high in the cycle after the acknowledge");

    req_size: assert property (@(posedge xaui_clk_156_25_out) disable iff (!reset_n)
        trigger_tlp |-> qwords_to_send >= tlp_qwords_t'(1) &&
                        qwords_to_send <= tlp_qwords_t'(`NIC_MAX_TLP_QWORDS))
        else $error("qwords_to_send outside 1 to 16 during a request");

    // --------------------
    // Reset and commit
    // --------------------
    // Second reset cycle onward, registers are cleared by then
    reset_quiet: assert property (@(posedge xaui_clk_156_25_out)
        !reset_n && $past(!reset_n) |-> !trigger_tlp && qwords_to_send == '0 &&
            committed_wr_address == '0 && good_frames == '0 &&
            bad_frames == '0 && dropped_frames == '0)
        else $error("Control outputs or counters active during reset");

    commit_room: assert property (@(posedge xaui_clk_156_25_out) disable iff (!reset_n)
        committed_wr_address != $past(committed_wr_address) |->
            committed_wr_address != host_rd_q)
        else $error("Commit filled the ring up to the host read address");

endmodule

bind nic_rx_top nic_rx_chk chk0 (
    .xaui_clk_156_25_out  (xaui_clk_156_25_out),
    .reset_n              (reset_n),
    .trigger_tlp          (trigger_tlp),
    .trigger_tlp_ack      (trigger_tlp_ack),
    .qwords_to_send       (qwords_to_send),
    .rd_addr_updated      (rd_addr_updated),
    .committed_rd_address (committed_rd_address),
    .committed_wr_address (committed_wr_address),
    .good_frames          (good_frames),
    .bad_frames           (bad_frames),
    .dropped_frames       (dropped_frames)
);

// File: tests/nic_rx_tb.sv
`timescale 1ns/1ps
`include "nic_defines.svh"

module nic_rx_tb
    import nic_pkg::*;
();

    localparam int CYCLE_LIMIT = 20000;                          // Full run needs about 5000
    localparam int RING_FREE   = (1 << `NIC_BUF_ADDR_BITS) - 1;  // One slot always empty
    localparam int MAX_REQ     = `NIC_MAX_TLP_QWORDS;

    logic         xaui_clk_156_25_out;
    logic         reset_n;
    qword_t       rx_data;
    byte_valid_t  rx_data_valid;
    logic         rx_good_frame;
    logic         rx_bad_frame;
    logic         rd_addr_updated;
    buf_addr_t    committed_rd_address;
    buf_addr_t    rd_addr;
    qword_t       rd_data;
    logic         trigger_tlp_ack;
    buf_addr_t    committed_wr_address;
    logic         trigger_tlp;
    tlp_qwords_t  qwords_to_send;
    frame_count_t good_frames;
    frame_count_t bad_frames;
    frame_count_t dropped_frames;

    qword_t       exp_q[$];        // Committed qwords not yet read
    buf_addr_t    host_ptr;        // Next qword the host reads
    buf_addr_t    rd_seen;         // Last address returned by strobe
    buf_addr_t    exp_wr;          // Model of committed_wr_address
    buf_addr_t    saved_wr;
    frame_count_t exp_good;
    frame_count_t exp_bad;
    frame_count_t exp_drop;
    int           errors    = 0;
    int           err_mark  = 0;
    int           tests_ok  = 0;
    int           tests_bad = 0;
    int           cycles    = 0;

    nic_rx_top dut0 (.*);

    initial begin
        xaui_clk_156_25_out = 1'b0;
        forever #20 xaui_clk_156_25_out = ~xaui_clk_156_25_out;   // 40 ns period
    end

    // --------------------
    // Watchdog
    // --------------------
    always @(posedge xaui_clk_156_25_out) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("Timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic expect_true(input logic ok, input string what);
        assert (ok) else begin
            errors++;
            $display("[FAIL] %0t: %s", $time, what);
        end
    endtask

    // MAC beats, then one strobe cycle with no valid lanes
    task automatic send_frame(input int len, input logic bad);
        qword_t    q;
        buf_addr_t used;
        logic      fits;
        used = exp_wr - rd_seen;                     // Occupied ring slots
        fits = (len <= RING_FREE - int'(used));
        for (int i = 0; i < len; i++) begin
            q = {$urandom, $urandom};
            @(posedge xaui_clk_156_25_out);
            rx_data       <= q;
            rx_data_valid <= byte_valid_t'($urandom_range(255, 1));
            if (fits && !bad) exp_q.push_back(q);
        end
        @(posedge xaui_clk_156_25_out);
        rx_data_valid <= '0;
        rx_good_frame <= !bad;
        rx_bad_frame  <= bad;
        @(posedge xaui_clk_156_25_out);
        rx_good_frame <= 1'b0;
        rx_bad_frame  <= 1'b0;
        if (!fits) begin
            exp_drop++;                              // End strobe only discards
        end else if (bad) begin
            exp_bad++;
        end else begin
            exp_good++;
            exp_wr = exp_wr + buf_addr_t'(len);
        end
        @(negedge xaui_clk_156_25_out);              // Commit has settled
    endtask

    task automatic check_counts(input string tag);
        expect_true(committed_wr_address == exp_wr, {tag, ": committed_wr_address wrong"});
        expect_true(good_frames == exp_good, {tag, ": good_frames wrong"});
        expect_true(bad_frames == exp_bad, {tag, ": bad_frames wrong"});
        expect_true(dropped_frames == exp_drop, {tag, ": dropped_frames wrong"});
    endtask

    // Host side of one request
    task automatic serve_request();
        int     n;
        int     exp_n;
        int     delay;
        qword_t want;
        while (trigger_tlp !== 1'b1) @(negedge xaui_clk_156_25_out);
        n     = int'(qwords_to_send);
        exp_n = (exp_q.size() < MAX_REQ) ? exp_q.size() : MAX_REQ;
        expect_true(n == exp_n, $sformatf("qwords_to_send %0d, expected %0d", n, exp_n));
        delay = $urandom_range(7, 0);
        repeat (delay) @(posedge xaui_clk_156_25_out);     // Host stalls the ack
        @(posedge xaui_clk_156_25_out);
        trigger_tlp_ack <= 1'b1;
        @(posedge xaui_clk_156_25_out);
        trigger_tlp_ack <= 1'b0;
        for (int i = 0; i < n; i++) begin
            @(posedge xaui_clk_156_25_out);
            rd_addr <= host_ptr;
            @(posedge xaui_clk_156_25_out);                 // Registered read
            @(negedge xaui_clk_156_25_out);
            want = (exp_q.size() > 0) ? exp_q.pop_front() : '0;
            expect_true(rd_data == want, $sformatf("rd_data wrong at address %0d", host_ptr));
            host_ptr = host_ptr + 1'b1;
        end
        @(posedge xaui_clk_156_25_out);
        rd_addr_updated      <= 1'b1;                      // Return read address
        committed_rd_address <= host_ptr;
        @(posedge xaui_clk_156_25_out);
        rd_addr_updated      <= 1'b0;
        rd_seen = host_ptr;
        @(negedge xaui_clk_156_25_out);
    endtask

    task automatic drain_buffer();
        while (exp_q.size() > 0) serve_request();
    endtask

    task automatic finish_test(input string name);
        if (errors == err_mark) begin
            tests_ok++;
            $display("Test %s: passed", name);
        end else begin
            tests_bad++;
            $display("Test %s: failed with %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        void'($urandom(77));
        reset_n              = 1'b0;
        rx_data              = '0;
        rx_data_valid        = '0;
        rx_good_frame        = 1'b0;
        rx_bad_frame         = 1'b0;
        rd_addr_updated      = 1'b0;
        committed_rd_address = '0;
        rd_addr              = '0;
        trigger_tlp_ack      = 1'b0;
        host_ptr             = '0;
        rd_seen              = '0;
        exp_wr               = '0;
        saved_wr             = '0;
        exp_good             = '0;
        exp_bad              = '0;
        exp_drop             = '0;
        repeat (3) @(posedge xaui_clk_156_25_out);
        reset_n <= 1'b1;

        repeat (8) begin
            @(negedge xaui_clk_156_25_out);
            expect_true(!trigger_tlp && qwords_to_send == '0 && committed_wr_address == '0 &&
                        good_frames == '0 && bad_frames == '0 && dropped_frames == '0,
                        "DUT not idle after reset");
        end
        finish_test("1 reset idle");

        for (int i = 0; i < 20; i++) begin
            send_frame($urandom_range(16, 1), 1'b0);
            check_counts("good frame");
        end
        drain_buffer();
        finish_test("2 good frames");

        saved_wr = exp_wr;
        send_frame($urandom_range(16, 4), 1'b1);
        check_counts("bad frame");
        send_frame(9, 1'b0);                         // Lands where the bad one was
        check_counts("frame after bad");
        expect_true(committed_wr_address == saved_wr + 9'd9, "frame after bad misplaced");
        drain_buffer();
        finish_test("3 bad frame rewind");

        repeat (3) send_frame(16, 1'b0);             // Three full requests
        check_counts("full requests");
        drain_buffer();
        finish_test("4 full requests");

        send_frame($urandom_range(15, 1), 1'b0);
        check_counts("tail frame");
        serve_request();                             // Issued after idle timeout
        expect_true(exp_q.size() == 0, "tail not covered by one request");
        finish_test("5 tail flush");

        repeat (28) send_frame(20, 1'b0);            // More than the ring holds
        check_counts("overrun");
        expect_true(dropped_frames != '0, "no frame dropped on overrun");
        expect_true(committed_wr_address != rd_seen, "commit reached host read address");
        drain_buffer();
        send_frame(20, 1'b0);                        // Room again after updates
        check_counts("after read update");
        drain_buffer();
        finish_test("6 overrun drop");

        $display("Tests passed: %0d, failed: %0d, check errors: %0d",
                 tests_ok, tests_bad, errors);
        if (errors == 0 && tests_bad == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
